/* dram_port_defs.svh */
// Widths of the SoC-side and DRAM-side AXI ports
// Both sides carry 64-bit data; the data-width converter is not present
// DRAM-side ID and address are the low bits of the SoC-side ones
`ifndef DRAM_PORT_DEFS_SVH
`define DRAM_PORT_DEFS_SVH

`default_nettype none

////////////////////
// ID widths
////////////////////

`define DRAM_SOC_ID_W 6
`define DRAM_MEM_ID_W 4

////////////////////
// Address widths
////////////////////

`define DRAM_SOC_ADDR_W 32
`define DRAM_MEM_ADDR_W 30

// Data path, same on both sides
`define DRAM_DATA_W 64
`define DRAM_STRB_W 8

// AXI burst length field
`define DRAM_LEN_W 8

`default_nettype wire

`endif

/* dram_port_pkg.sv */
// Channel structs for the SoC and DRAM AXI ports, no user fields
// AW and AR share one address struct per side
// Control state enums of the ID restore stage
`include "dram_port_defs.svh"

`default_nettype none

package dram_port_pkg;

  ////////////////////
  // SoC side
  ////////////////////

  typedef struct packed {
    logic [`DRAM_SOC_ID_W-1:0]   id;
    logic [`DRAM_SOC_ADDR_W-1:0] addr;
    logic [`DRAM_LEN_W-1:0]      len;
    logic [2:0]                  size;
    logic [1:0]                  burst;
  } soc_ax_t;

  typedef struct packed {
    logic [`DRAM_SOC_ID_W-1:0] id;
    logic [1:0]                resp;
  } soc_b_t;

  typedef struct packed {
    logic [`DRAM_SOC_ID_W-1:0] id;
    logic [`DRAM_DATA_W-1:0]   data;
    logic [1:0]                resp;
    logic                      last;
  } soc_r_t;

  // Write data is identical on both sides
  typedef struct packed {
    logic [`DRAM_DATA_W-1:0] data;
    logic [`DRAM_STRB_W-1:0] strb;
    logic                    last;
  } w_chan_t;

  ////////////////////
  // DRAM side
  ////////////////////

  typedef struct packed {
    logic [`DRAM_MEM_ID_W-1:0]   id;
    logic [`DRAM_MEM_ADDR_W-1:0] addr;
    logic [`DRAM_LEN_W-1:0]      len;
    logic [2:0]                  size;
    logic [1:0]                  burst;
  } mem_ax_t;

  typedef struct packed {
    logic [`DRAM_MEM_ID_W-1:0] id;
    logic [1:0]                resp;
  } mem_b_t;

  typedef struct packed {
    logic [`DRAM_MEM_ID_W-1:0] id;
    logic [`DRAM_DATA_W-1:0]   data;
    logic [1:0]                resp;
    logic                      last;
  } mem_r_t;

  // One transaction in flight per direction
  typedef enum logic {WR_IDLE, WR_BUSY} wr_state_e;
  typedef enum logic {RD_IDLE, RD_BUSY} rd_state_e;

endpackage

`default_nettype wire

/* dram_spill_reg.sv */
// Two-entry spill register for one valid/ready channel
// Both in_ready_o and out_valid_o come straight from flops
// Adds one cycle of latency when empty
`timescale 1ns/1ps
`default_nettype none

module dram_spill_reg #(
  parameter type chan_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  chan_t in_data_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  output chan_t out_data_o,
  output logic  out_valid_o,
  input  logic  out_ready_i
);

  // Slot 0 drives the output, slot 1 catches the overflow
  logic  full0_q;
  logic  full1_q;
  chan_t data0_q;
  chan_t data1_q;
  logic  push;
  logic  pop;

  assign in_ready_o  = ~full1_q;
  assign out_valid_o = full0_q;
  assign out_data_o  = data0_q;

  assign push = in_valid_i & in_ready_o;
  assign pop  = full0_q & out_ready_i;

  ////////////////////
  // Occupancy
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full0_q <= 1'b0;
      full1_q <= 1'b0;
    end else if (full1_q) begin
      // Input is stalled here, only draining
      if (pop) begin
        full1_q <= 1'b0;
      end
    end else if (full0_q) begin
      if (push && !pop) begin
        full1_q <= 1'b1;
      end else if (!push && pop) begin
        full0_q <= 1'b0;
      end
    end else if (push) begin
      full0_q <= 1'b1;
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (full1_q) begin
      if (pop) begin
        data0_q <= data1_q;
      end
    end else if (push) begin
      // Park in slot 1 only when slot 0 is held
      if (full0_q && !pop) begin
        data1_q <= in_data_i;
      end else begin
        data0_q <= in_data_i;
      end
    end
  end

endmodule

`default_nettype wire

/* dram_id_ctrl.sv */
// ID and address narrowing between SoC and DRAM AXI ports
// At most one write and one read outstanding; later requests wait
// Responses get the stored full SoC ID, the DRAM ID is ignored
// Purely combinational on the data paths
`timescale 1ns/1ps

`include "dram_port_defs.svh"

`default_nettype none

module dram_id_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // SoC side
  input  dram_port_pkg::soc_ax_t  soc_aw_i,
  input  logic                    soc_aw_valid_i,
  output logic                    soc_aw_ready_o,
  input  dram_port_pkg::w_chan_t  soc_w_i,
  input  logic                    soc_w_valid_i,
  output logic                    soc_w_ready_o,
  output dram_port_pkg::soc_b_t   soc_b_o,
  output logic                    soc_b_valid_o,
  input  logic                    soc_b_ready_i,
  input  dram_port_pkg::soc_ax_t  soc_ar_i,
  input  logic                    soc_ar_valid_i,
  output logic                    soc_ar_ready_o,
  output dram_port_pkg::soc_r_t   soc_r_o,
  output logic                    soc_r_valid_o,
  input  logic                    soc_r_ready_i,
  // DRAM side
  output dram_port_pkg::mem_ax_t  mem_aw_o,
  output logic                    mem_aw_valid_o,
  input  logic                    mem_aw_ready_i,
  output dram_port_pkg::w_chan_t  mem_w_o,
  output logic                    mem_w_valid_o,
  input  logic                    mem_w_ready_i,
  input  dram_port_pkg::mem_b_t   mem_b_i,
  input  logic                    mem_b_valid_i,
  output logic                    mem_b_ready_o,
  output dram_port_pkg::mem_ax_t  mem_ar_o,
  output logic                    mem_ar_valid_o,
  input  logic                    mem_ar_ready_i,
  input  dram_port_pkg::mem_r_t   mem_r_i,
  input  logic                    mem_r_valid_i,
  output logic                    mem_r_ready_o
);

  import dram_port_pkg::*;

  wr_state_e                 wr_state_q;
  rd_state_e                 rd_state_q;
  logic [`DRAM_SOC_ID_W-1:0] wr_id_q;
  logic [`DRAM_SOC_ID_W-1:0] rd_id_q;
  logic                      aw_fire;
  logic                      ar_fire;
  logic                      b_fire;
  logic                      r_last_fire;

  ////////////////////
  // Write path
  ////////////////////

  // Address only passes while no write is open
  assign mem_aw_valid_o = soc_aw_valid_i & (wr_state_q == WR_IDLE);
  assign soc_aw_ready_o = mem_aw_ready_i & (wr_state_q == WR_IDLE);

  assign mem_aw_o = '{
    id:    soc_aw_i.id[`DRAM_MEM_ID_W-1:0],
    addr:  soc_aw_i.addr[`DRAM_MEM_ADDR_W-1:0],
    len:   soc_aw_i.len,
    size:  soc_aw_i.size,
    burst: soc_aw_i.burst
  };

  // W is not tied to the AW limit
  assign mem_w_o       = soc_w_i;
  assign mem_w_valid_o = soc_w_valid_i;
  assign soc_w_ready_o = mem_w_ready_i;

  assign soc_b_o       = '{id: wr_id_q, resp: mem_b_i.resp};
  assign soc_b_valid_o = mem_b_valid_i;
  assign mem_b_ready_o = soc_b_ready_i;

  assign aw_fire = mem_aw_valid_o & mem_aw_ready_i;
  assign b_fire  = mem_b_valid_i & soc_b_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_state_q <= WR_IDLE;
    end else begin
      case (wr_state_q)
        WR_IDLE: if (aw_fire) wr_state_q <= WR_BUSY;
        WR_BUSY: if (b_fire) wr_state_q <= WR_IDLE;
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      wr_id_q <= soc_aw_i.id;
    end
  end

  ////////////////////
  // Read path
  ////////////////////

  assign mem_ar_valid_o = soc_ar_valid_i & (rd_state_q == RD_IDLE);
  assign soc_ar_ready_o = mem_ar_ready_i & (rd_state_q == RD_IDLE);

  assign mem_ar_o = '{
    id:    soc_ar_i.id[`DRAM_MEM_ID_W-1:0],
    addr:  soc_ar_i.addr[`DRAM_MEM_ADDR_W-1:0],
    len:   soc_ar_i.len,
    size:  soc_ar_i.size,
    burst: soc_ar_i.burst
  };

  // Every beat of the burst gets the stored ID
  assign soc_r_o = '{
    id:   rd_id_q,
    data: mem_r_i.data,
    resp: mem_r_i.resp,
    last: mem_r_i.last
  };
  assign soc_r_valid_o = mem_r_valid_i;
  assign mem_r_ready_o = soc_r_ready_i;

  assign ar_fire     = mem_ar_valid_o & mem_ar_ready_i;
  assign r_last_fire = mem_r_valid_i & soc_r_ready_i & mem_r_i.last;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_state_q <= RD_IDLE;
    end else begin
      case (rd_state_q)
        RD_IDLE: if (ar_fire) rd_state_q <= RD_BUSY;
        RD_BUSY: if (r_last_fire) rd_state_q <= RD_IDLE;
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      rd_id_q <= soc_ar_i.id;
    end
  end

endmodule

`default_nettype wire

/* dram_port_top.sv */
// SoC AXI to DRAM AXI bridge, single clock domain
// Spill cut, ID/address narrowing, spill cut; two cycles each way
// DRAM side is exposed as ports for an external memory model
`timescale 1ns/1ps
`default_nettype none

module dram_port_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // SoC side
  input  dram_port_pkg::soc_ax_t  soc_aw_i,
  input  logic                    soc_aw_valid_i,
  output logic                    soc_aw_ready_o,
  input  dram_port_pkg::w_chan_t  soc_w_i,
  input  logic                    soc_w_valid_i,
  output logic                    soc_w_ready_o,
  output dram_port_pkg::soc_b_t   soc_b_o,
  output logic                    soc_b_valid_o,
  input  logic                    soc_b_ready_i,
  input  dram_port_pkg::soc_ax_t  soc_ar_i,
  input  logic                    soc_ar_valid_i,
  output logic                    soc_ar_ready_o,
  output dram_port_pkg::soc_r_t   soc_r_o,
  output logic                    soc_r_valid_o,
  input  logic                    soc_r_ready_i,
  // DRAM side
  output dram_port_pkg::mem_ax_t  mem_aw_o,
  output logic                    mem_aw_valid_o,
  input  logic                    mem_aw_ready_i,
  output dram_port_pkg::w_chan_t  mem_w_o,
  output logic                    mem_w_valid_o,
  input  logic                    mem_w_ready_i,
  input  dram_port_pkg::mem_b_t   mem_b_i,
  input  logic                    mem_b_valid_i,
  output logic                    mem_b_ready_o,
  output dram_port_pkg::mem_ax_t  mem_ar_o,
  output logic                    mem_ar_valid_o,
  input  logic                    mem_ar_ready_i,
  input  dram_port_pkg::mem_r_t   mem_r_i,
  input  logic                    mem_r_valid_i,
  output logic                    mem_r_ready_o
);

  import dram_port_pkg::*;

  // Control stage, SoC-facing side
  soc_ax_t ctl_soc_aw;
  logic    ctl_soc_aw_valid, ctl_soc_aw_ready;
  w_chan_t ctl_soc_w;
  logic    ctl_soc_w_valid, ctl_soc_w_ready;
  soc_b_t  ctl_soc_b;
  logic    ctl_soc_b_valid, ctl_soc_b_ready;
  soc_ax_t ctl_soc_ar;
  logic    ctl_soc_ar_valid, ctl_soc_ar_ready;
  soc_r_t  ctl_soc_r;
  logic    ctl_soc_r_valid, ctl_soc_r_ready;

  // Control stage, DRAM-facing side
  mem_ax_t ctl_mem_aw;
  logic    ctl_mem_aw_valid, ctl_mem_aw_ready;
  w_chan_t ctl_mem_w;
  logic    ctl_mem_w_valid, ctl_mem_w_ready;
  mem_b_t  ctl_mem_b;
  logic    ctl_mem_b_valid, ctl_mem_b_ready;
  mem_ax_t ctl_mem_ar;
  logic    ctl_mem_ar_valid, ctl_mem_ar_ready;
  mem_r_t  ctl_mem_r;
  logic    ctl_mem_r_valid, ctl_mem_r_ready;

  ////////////////////
  // SoC-side cuts
  ////////////////////

  dram_spill_reg #(.chan_t(soc_ax_t)) i_soc_cut_aw (
    .clk_i, .rst_i,
    .in_data_i  (soc_aw_i),   .in_valid_i (soc_aw_valid_i),   .in_ready_o (soc_aw_ready_o),
    .out_data_o (ctl_soc_aw), .out_valid_o(ctl_soc_aw_valid), .out_ready_i(ctl_soc_aw_ready)
  );

  dram_spill_reg #(.chan_t(w_chan_t)) i_soc_cut_w (
    .clk_i, .rst_i,
    .in_data_i  (soc_w_i),   .in_valid_i (soc_w_valid_i),   .in_ready_o (soc_w_ready_o),
    .out_data_o (ctl_soc_w), .out_valid_o(ctl_soc_w_valid), .out_ready_i(ctl_soc_w_ready)
  );

  // Response channels run from the control stage out to the SoC
  dram_spill_reg #(.chan_t(soc_b_t)) i_soc_cut_b (
    .clk_i, .rst_i,
    .in_data_i  (ctl_soc_b), .in_valid_i (ctl_soc_b_valid), .in_ready_o (ctl_soc_b_ready),
    .out_data_o (soc_b_o),   .out_valid_o(soc_b_valid_o),   .out_ready_i(soc_b_ready_i)
  );

  dram_spill_reg #(.chan_t(soc_ax_t)) i_soc_cut_ar (
    .clk_i, .rst_i,
    .in_data_i  (soc_ar_i),   .in_valid_i (soc_ar_valid_i),   .in_ready_o (soc_ar_ready_o),
    .out_data_o (ctl_soc_ar), .out_valid_o(ctl_soc_ar_valid), .out_ready_i(ctl_soc_ar_ready)
  );

  dram_spill_reg #(.chan_t(soc_r_t)) i_soc_cut_r (
    .clk_i, .rst_i,
    .in_data_i  (ctl_soc_r), .in_valid_i (ctl_soc_r_valid), .in_ready_o (ctl_soc_r_ready),
    .out_data_o (soc_r_o),   .out_valid_o(soc_r_valid_o),   .out_ready_i(soc_r_ready_i)
  );

  ////////////////////
  // Control stage
  ////////////////////

  dram_id_ctrl i_id_ctrl (
    .clk_i, .rst_i,
    .soc_aw_i      (ctl_soc_aw), .soc_aw_valid_i(ctl_soc_aw_valid),
    .soc_aw_ready_o(ctl_soc_aw_ready),
    .soc_w_i       (ctl_soc_w),  .soc_w_valid_i (ctl_soc_w_valid),
    .soc_w_ready_o (ctl_soc_w_ready),
    .soc_b_o       (ctl_soc_b),  .soc_b_valid_o (ctl_soc_b_valid),
    .soc_b_ready_i (ctl_soc_b_ready),
    .soc_ar_i      (ctl_soc_ar), .soc_ar_valid_i(ctl_soc_ar_valid),
    .soc_ar_ready_o(ctl_soc_ar_ready),
    .soc_r_o       (ctl_soc_r),  .soc_r_valid_o (ctl_soc_r_valid),
    .soc_r_ready_i (ctl_soc_r_ready),
    .mem_aw_o      (ctl_mem_aw), .mem_aw_valid_o(ctl_mem_aw_valid),
    .mem_aw_ready_i(ctl_mem_aw_ready),
    .mem_w_o       (ctl_mem_w),  .mem_w_valid_o (ctl_mem_w_valid),
    .mem_w_ready_i (ctl_mem_w_ready),
    .mem_b_i       (ctl_mem_b),  .mem_b_valid_i (ctl_mem_b_valid),
    .mem_b_ready_o (ctl_mem_b_ready),
    .mem_ar_o      (ctl_mem_ar), .mem_ar_valid_o(ctl_mem_ar_valid),
    .mem_ar_ready_i(ctl_mem_ar_ready),
    .mem_r_i       (ctl_mem_r),  .mem_r_valid_i (ctl_mem_r_valid),
    .mem_r_ready_o (ctl_mem_r_ready)
  );

  ////////////////////
  // DRAM-side cuts
  ////////////////////

  dram_spill_reg #(.chan_t(mem_ax_t)) i_mem_cut_aw (
    .clk_i, .rst_i,
    .in_data_i  (ctl_mem_aw), .in_valid_i (ctl_mem_aw_valid), .in_ready_o (ctl_mem_aw_ready),
    .out_data_o (mem_aw_o),   .out_valid_o(mem_aw_valid_o),   .out_ready_i(mem_aw_ready_i)
  );

  dram_spill_reg #(.chan_t(w_chan_t)) i_mem_cut_w (
    .clk_i, .rst_i,
    .in_data_i  (ctl_mem_w), .in_valid_i (ctl_mem_w_valid), .in_ready_o (ctl_mem_w_ready),
    .out_data_o (mem_w_o),   .out_valid_o(mem_w_valid_o),   .out_ready_i(mem_w_ready_i)
  );

  dram_spill_reg #(.chan_t(mem_b_t)) i_mem_cut_b (
    .clk_i, .rst_i,
    .in_data_i  (mem_b_i),   .in_valid_i (mem_b_valid_i),   .in_ready_o (mem_b_ready_o),
    .out_data_o (ctl_mem_b), .out_valid_o(ctl_mem_b_valid), .out_ready_i(ctl_mem_b_ready)
  );

  dram_spill_reg #(.chan_t(mem_ax_t)) i_mem_cut_ar (
    .clk_i, .rst_i,
    .in_data_i  (ctl_mem_ar), .in_valid_i (ctl_mem_ar_valid), .in_ready_o (ctl_mem_ar_ready),
    .out_data_o (mem_ar_o),   .out_valid_o(mem_ar_valid_o),   .out_ready_i(mem_ar_ready_i)
  );

  dram_spill_reg #(.chan_t(mem_r_t)) i_mem_cut_r (
    .clk_i, .rst_i,
    .in_data_i  (mem_r_i),   .in_valid_i (mem_r_valid_i),   .in_ready_o (mem_r_ready_o),
    .out_data_o (ctl_mem_r), .out_valid_o(ctl_mem_r_valid), .out_ready_i(ctl_mem_r_ready)
  );

endmodule

`default_nettype wire

/* tb_dram_port_asserts.sv */
// Concurrent checks on the ID control stage, bound into dram_id_ctrl
// Connects by name to the stage's ports
// Open transactions are tracked from the handshakes alone
`timescale 1ns/1ps
`default_nettype none

module tb_dram_port_asserts (
  input logic                      clk_i,
  input logic                      rst_i,
  input logic                      mem_aw_valid_o,
  input logic                      mem_aw_ready_i,
  input logic                      mem_ar_valid_o,
  input logic                      mem_ar_ready_i,
  input dram_port_pkg::soc_b_t     soc_b_o,
  input logic                      soc_b_valid_o,
  input logic                      soc_b_ready_i,
  input dram_port_pkg::soc_r_t     soc_r_o,
  input logic                      soc_r_valid_o,
  input logic                      soc_r_ready_i
);

  logic aw_fire;
  logic ar_fire;
  logic b_fire;
  logic r_last_fire;
  logic wr_open_q;
  logic rd_open_q;

  assign aw_fire     = mem_aw_valid_o & mem_aw_ready_i;
  assign ar_fire     = mem_ar_valid_o & mem_ar_ready_i;
  assign b_fire      = soc_b_valid_o & soc_b_ready_i;
  assign r_last_fire = soc_r_valid_o & soc_r_ready_i & soc_r_o.last;

  // Open from the DRAM address transfer to the SoC response
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_open_q <= 1'b0;
    end else if (aw_fire) begin
      wr_open_q <= 1'b1;
    end else if (b_fire) begin
      wr_open_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_open_q <= 1'b0;
    end else if (ar_fire) begin
      rd_open_q <= 1'b1;
    end else if (r_last_fire) begin
      rd_open_q <= 1'b0;
    end
  end

  // No new write address while a write is open
  aw_one_outstanding: assert property (
    @(posedge clk_i) disable iff (rst_i)
    aw_fire |-> !wr_open_q
  ) else $error("write address passed while a write is outstanding");

  // Same limit on reads
  ar_one_outstanding: assert property (
    @(posedge clk_i) disable iff (rst_i)
    ar_fire |-> !rd_open_q
  ) else $error("read address passed while a read is outstanding");

  // B holds until taken
  b_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (soc_b_valid_o && !soc_b_ready_i) |=> (soc_b_valid_o && $stable(soc_b_o))
  ) else $error("write response changed before it was accepted");

endmodule

bind dram_id_ctrl tb_dram_port_asserts i_id_ctrl_asserts (.*);

`default_nettype wire

/* tb_dram_port.sv */
// Testbench for the SoC to DRAM AXI bridge, acting as SoC master and DRAM model
// Runs the data file three times: one at a time, grouped back to back, with stalls
// Inputs change on the falling edge; handshakes are sampled on the rising edge
`timescale 1ns/1ps

`include "dram_port_defs.svh"

`default_nettype none

module tb_dram_port;

  import dram_port_pkg::*;

  localparam int MAX_LINES = 64;

  logic    clk_i;
  logic    rst_i;
  soc_ax_t soc_aw;
  logic    soc_aw_valid, soc_aw_ready;
  w_chan_t soc_w;
  logic    soc_w_valid, soc_w_ready;
  soc_b_t  soc_b;
  logic    soc_b_valid, soc_b_ready;
  soc_ax_t soc_ar;
  logic    soc_ar_valid, soc_ar_ready;
  soc_r_t  soc_r;
  logic    soc_r_valid, soc_r_ready;
  mem_ax_t mem_aw;
  logic    mem_aw_valid, mem_aw_ready;
  w_chan_t mem_w;
  logic    mem_w_valid, mem_w_ready;
  mem_b_t  mem_b;
  logic    mem_b_valid, mem_b_ready;
  mem_ax_t mem_ar;
  logic    mem_ar_valid, mem_ar_ready;
  mem_r_t  mem_r;
  logic    mem_r_valid, mem_r_ready;

  // Transactions from the data file
  logic                      line_wr   [MAX_LINES];
  logic [`DRAM_SOC_ID_W-1:0] line_id   [MAX_LINES];
  logic [31:0]               line_addr [MAX_LINES];
  logic [`DRAM_LEN_W-1:0]    line_len  [MAX_LINES];
  logic [31:0]               line_seed [MAX_LINES];
  logic [`DRAM_MEM_ID_W-1:0] line_mid  [MAX_LINES];
  int                        n_lines;
  logic                      lines_loaded;

  // Scoreboard queues, filled when a request is issued
  mem_ax_t exp_mem_aw_q[$];
  mem_ax_t exp_mem_ar_q[$];
  w_chan_t exp_w_q[$];
  soc_b_t  exp_b_q[$];
  soc_r_t  exp_r_q[$];
  mem_b_t  model_b_q[$];
  mem_r_t  model_r_q[$];
  mem_ax_t model_aw_q[$];
  mem_ax_t model_ar_q[$];
  logic [`DRAM_DATA_W-1:0] model_w_q[$];

  // DRAM contents and the testbench's own expectation, by 64-bit word index
  logic [63:0] model_mem [logic [26:0]];
  logic [63:0] ref_mem   [logic [26:0]];

  integer seed;
  logic   stall_en;
  logic   wr_open;
  logic   rd_open;
  int     errors;
  int     wr_issued, rd_issued;
  int     b_count, r_last_count;

  dram_port_top i_dram_port_top (
    .clk_i, .rst_i,
    .soc_aw_i(soc_aw), .soc_aw_valid_i(soc_aw_valid), .soc_aw_ready_o(soc_aw_ready),
    .soc_w_i(soc_w), .soc_w_valid_i(soc_w_valid), .soc_w_ready_o(soc_w_ready),
    .soc_b_o(soc_b), .soc_b_valid_o(soc_b_valid), .soc_b_ready_i(soc_b_ready),
    .soc_ar_i(soc_ar), .soc_ar_valid_i(soc_ar_valid), .soc_ar_ready_o(soc_ar_ready),
    .soc_r_o(soc_r), .soc_r_valid_o(soc_r_valid), .soc_r_ready_i(soc_r_ready),
    .mem_aw_o(mem_aw), .mem_aw_valid_o(mem_aw_valid), .mem_aw_ready_i(mem_aw_ready),
    .mem_w_o(mem_w), .mem_w_valid_o(mem_w_valid), .mem_w_ready_i(mem_w_ready),
    .mem_b_i(mem_b), .mem_b_valid_i(mem_b_valid), .mem_b_ready_o(mem_b_ready),
    .mem_ar_o(mem_ar), .mem_ar_valid_o(mem_ar_valid), .mem_ar_ready_i(mem_ar_ready),
    .mem_r_i(mem_r), .mem_r_valid_i(mem_r_valid), .mem_r_ready_o(mem_r_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic pick_ready();
    int r;
    r = $random(seed);
    return !stall_en || (r[1:0] != 2'b00);
  endfunction

  function automatic logic [63:0] fill_word(logic [26:0] idx);
    return {5'b10101, idx, 5'b01010, ~idx};
  endfunction

  function automatic logic [63:0] beat_data(logic [31:0] s, int beat);
    return {s + 32'(beat), s ^ (32'(beat) * 32'h9e3779b9)};
  endfunction

  task automatic cmp_ax(string name, mem_ax_t got, mem_ax_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_w(string name, w_chan_t got, w_chan_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_b(string name, soc_b_t got, soc_b_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_r(string name, soc_r_t got, soc_r_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////
  // SoC master
  ////////////////////

  // Called on a falling edge, returns on a falling edge
  task automatic issue_write(int n);
    soc_ax_t     ax;
    w_chan_t     w;
    logic [26:0] idx;
    ax = '{id: line_id[n], addr: line_addr[n], len: line_len[n], size: 3'd3, burst: 2'b01};
    exp_mem_aw_q.push_back('{id: ax.id[3:0], addr: ax.addr[29:0], len: ax.len,
                             size: ax.size, burst: ax.burst});
    model_b_q.push_back('{id: line_mid[n], resp: line_mid[n][1:0]});
    exp_b_q.push_back('{id: line_id[n], resp: line_mid[n][1:0]});
    for (int i = 0; i <= int'(line_len[n]); i++) begin
      idx = line_addr[n][29:3] + 27'(i);
      ref_mem[idx] = beat_data(line_seed[n], i);
      exp_w_q.push_back('{data: ref_mem[idx], strb: 8'hff, last: (i == int'(line_len[n]))});
    end
    wr_issued++;
    soc_aw = ax;
    soc_aw_valid = 1'b1;
    @(posedge clk_i);
    while (!soc_aw_ready) @(posedge clk_i);
    @(negedge clk_i);
    soc_aw_valid = 1'b0;
    for (int i = 0; i <= int'(line_len[n]); i++) begin
      w = '{data: beat_data(line_seed[n], i), strb: 8'hff, last: (i == int'(line_len[n]))};
      soc_w = w;
      soc_w_valid = 1'b1;
      @(posedge clk_i);
      while (!soc_w_ready) @(posedge clk_i);
      @(negedge clk_i);
      soc_w_valid = 1'b0;
    end
  endtask

  task automatic issue_read(int n);
    soc_ax_t     ax;
    logic [26:0] idx;
    logic [63:0] d;
    ax = '{id: line_id[n], addr: line_addr[n], len: line_len[n], size: 3'd3, burst: 2'b01};
    exp_mem_ar_q.push_back('{id: ax.id[3:0], addr: ax.addr[29:0], len: ax.len,
                             size: ax.size, burst: ax.burst});
    model_r_q.push_back('{id: line_mid[n], data: '0, resp: line_mid[n][1:0], last: 1'b0});
    for (int i = 0; i <= int'(line_len[n]); i++) begin
      idx = line_addr[n][29:3] + 27'(i);
      d = ref_mem.exists(idx) ? ref_mem[idx] : fill_word(idx);
      exp_r_q.push_back('{id: line_id[n], data: d, resp: line_mid[n][1:0],
                          last: (i == int'(line_len[n]))});
    end
    rd_issued++;
    soc_ar = ax;
    soc_ar_valid = 1'b1;
    @(posedge clk_i);
    while (!soc_ar_ready) @(posedge clk_i);
    @(negedge clk_i);
    soc_ar_valid = 1'b0;
  endtask

  task automatic wait_idle();
    wait (b_count == wr_issued && r_last_count == rd_issued);
    @(negedge clk_i);
  endtask

  // Grouped mode issues runs of the same operation without waiting in between
  task automatic run_pass(string name, logic grouped, logic stalls);
    int err_start;
    err_start = errors;
    stall_en = stalls;
    for (int n = 0; n < n_lines; n++) begin
      if (!grouped || (n > 0 && line_wr[n] != line_wr[n-1])) wait_idle();
      if (line_wr[n]) issue_write(n);
      else issue_read(n);
    end
    wait_idle();
    if (exp_mem_aw_q.size() + exp_mem_ar_q.size() + exp_w_q.size() +
        exp_b_q.size() + exp_r_q.size() != 0) begin
      $display("Test %s ended with expected transfers that never arrived", name);
      errors++;
    end
    $display("test %s: %0d transactions, %0d errors", name, n_lines, errors - err_start);
  endtask

  ////////////////////
  // Response receivers
  ////////////////////

  initial begin
    forever begin
      @(negedge clk_i);
      soc_b_ready = pick_ready();
      @(posedge clk_i);
      if (soc_b_valid && soc_b_ready) begin
        if (exp_b_q.size() == 0) begin
          $display("Write response arrived with no write outstanding");
          errors++;
        end else begin
          cmp_b("soc_b", soc_b, exp_b_q.pop_front());
        end
        b_count++;
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk_i);
      soc_r_ready = pick_ready();
      @(posedge clk_i);
      if (soc_r_valid && soc_r_ready) begin
        if (exp_r_q.size() == 0) begin
          $display("Read data arrived with no read beat expected");
          errors++;
        end else begin
          cmp_r("soc_r", soc_r, exp_r_q.pop_front());
        end
        if (soc_r.last) r_last_count++;
      end
    end
  end

  ////////////////////
  // DRAM model
  ////////////////////

  initial begin
    forever begin
      @(negedge clk_i);
      mem_aw_ready = pick_ready();
      @(posedge clk_i);
      if (mem_aw_valid && mem_aw_ready) begin
        if (wr_open) begin
          $display("Second write address reached DRAM before the first write response");
          errors++;
        end
        wr_open = 1'b1;
        if (exp_mem_aw_q.size() > 0) begin
          cmp_ax("mem_aw", mem_aw, exp_mem_aw_q.pop_front());
        end else begin
          $display("Write address reached DRAM with no write issued");
          errors++;
        end
        model_aw_q.push_back(mem_aw);
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk_i);
      mem_w_ready = pick_ready();
      @(posedge clk_i);
      if (mem_w_valid && mem_w_ready) begin
        if (exp_w_q.size() > 0) begin
          cmp_w("mem_w", mem_w, exp_w_q.pop_front());
        end else begin
          $display("Write data reached DRAM with no beat expected");
          errors++;
        end
        model_w_q.push_back(mem_w.data);
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk_i);
      mem_ar_ready = pick_ready();
      @(posedge clk_i);
      if (mem_ar_valid && mem_ar_ready) begin
        if (rd_open) begin
          $display("Second read address reached DRAM before the first read completed");
          errors++;
        end
        rd_open = 1'b1;
        if (exp_mem_ar_q.size() > 0) begin
          cmp_ax("mem_ar", mem_ar, exp_mem_ar_q.pop_front());
        end else begin
          $display("Read address reached DRAM with no read issued");
          errors++;
        end
        model_ar_q.push_back(mem_ar);
      end
    end
  end

  // Stores the burst once all its beats are in, then answers on B
  initial begin : b_model
    mem_ax_t     ax;
    logic        b_done;
    logic [26:0] idx;
    b_done = 1'b0;
    forever begin
      @(negedge clk_i);
      if (b_done) begin
        mem_b_valid = 1'b0;
        b_done = 1'b0;
      end
      if (!mem_b_valid && model_aw_q.size() > 0 && model_b_q.size() > 0 &&
          model_w_q.size() > int'(model_aw_q[0].len)) begin
        ax = model_aw_q.pop_front();
        for (int i = 0; i <= int'(ax.len); i++) begin
          idx = ax.addr[29:3] + 27'(i);
          model_mem[idx] = model_w_q.pop_front();
        end
        mem_b = model_b_q.pop_front();
        mem_b_valid = 1'b1;
      end
      @(posedge clk_i);
      if (mem_b_valid && mem_b_ready) begin
        b_done = 1'b1;
        wr_open = 1'b0;
      end
    end
  end

  initial begin : r_model
    mem_ax_t     ax;
    mem_r_t      info;
    logic        busy;
    logic        accepted;
    int          beat;
    logic [26:0] idx;
    busy = 1'b0;
    accepted = 1'b0;
    beat = 0;
    forever begin
      @(negedge clk_i);
      if (accepted) begin
        accepted = 1'b0;
        mem_r_valid = 1'b0;
        if (mem_r.last) busy = 1'b0;
        else beat++;
      end
      if (!busy && model_ar_q.size() > 0 && model_r_q.size() > 0) begin
        ax = model_ar_q.pop_front();
        info = model_r_q.pop_front();
        busy = 1'b1;
        beat = 0;
      end
      if (busy) begin
        idx = ax.addr[29:3] + 27'(beat);
        mem_r = '{id: info.id, resp: info.resp, last: (beat == int'(ax.len)),
                  data: model_mem.exists(idx) ? model_mem[idx] : fill_word(idx)};
        mem_r_valid = 1'b1;
      end
      @(posedge clk_i);
      if (mem_r_valid && mem_r_ready) begin
        accepted = 1'b1;
        if (mem_r.last) rd_open = 1'b0;
      end
    end
  end

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    wait (lines_loaded);
    repeat (n_lines * 200 * 3 + 100) @(posedge clk_i);
    $display("Timeout: transactions did not complete in %0d cycles", n_lines * 600 + 100);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main
    int    fd;
    int    cnt;
    string line;
    string op;
    logic [31:0] f_id, f_addr, f_len, f_seed, f_mid;
    seed = 97;
    rst_i = 1'b1;
    soc_aw = '0;
    soc_aw_valid = 1'b0;
    soc_w = '0;
    soc_w_valid = 1'b0;
    soc_b_ready = 1'b0;
    soc_ar = '0;
    soc_ar_valid = 1'b0;
    soc_r_ready = 1'b0;
    mem_aw_ready = 1'b0;
    mem_w_ready = 1'b0;
    mem_b = '0;
    mem_b_valid = 1'b0;
    mem_ar_ready = 1'b0;
    mem_r = '0;
    mem_r_valid = 1'b0;
    stall_en = 1'b0;
    wr_open = 1'b0;
    rd_open = 1'b0;
    errors = 0;
    wr_issued = 0;
    rd_issued = 0;
    b_count = 0;
    r_last_count = 0;
    n_lines = 0;
    lines_loaded = 1'b0;

    fd = $fopen("dram_port_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus data file");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      while (!$feof(fd) && n_lines < MAX_LINES) begin
        cnt = $fgets(line, fd);
        if (cnt > 0 && line.len() > 1 && line[0] != "#") begin
          cnt = $sscanf(line, "%s %h %h %h %h %h", op, f_id, f_addr, f_len, f_seed, f_mid);
          if (cnt == 6) begin
            line_wr[n_lines]   = (op == "W");
            line_id[n_lines]   = f_id[`DRAM_SOC_ID_W-1:0];
            line_addr[n_lines] = f_addr;
            line_len[n_lines]  = f_len[`DRAM_LEN_W-1:0];
            line_seed[n_lines] = f_seed;
            line_mid[n_lines]  = f_mid[`DRAM_MEM_ID_W-1:0];
            n_lines++;
          end
        end
      end
      $fclose(fd);
      lines_loaded = 1'b1;

      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      @(negedge clk_i);

      run_pass("one_at_a_time", 1'b0, 1'b0);
      run_pass("back_to_back", 1'b1, 1'b0);
      run_pass("random_stalls", 1'b1, 1'b1);

      if (n_lines == 0) begin
        $display("No transactions found in the data file");
        errors++;
      end
      $display("Summary: 3 tests, %0d transactions each, %0d errors", n_lines, errors);
      if (errors == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dram_port_testdata.txt */
# op(W/R) soc_id addr len write_seed dram_resp_id, all hex
# reads follow the writes they read back; the DRAM id's low 2 bits give resp
W 2a c0000100 3 11111111 5
W 3f 40000200 0 22222222 a
W 15 80000300 1 33333333 0
R 2b c0000100 3 00000000 7
R 31 40000200 0 00000000 f
R 08 80000300 1 00000000 2
W 27 00001000 7 44444444 c
W 3c f0001040 2 55555555 3
R 1e 00001000 7 00000000 9
R 39 f0001040 2 00000000 4
R 06 c0000110 1 00000000 1
W 2a c0000100 0 66666666 e
W 11 7fff0008 1 77777777 6
R 22 c0000100 3 00000000 b
R 3e 7fff0008 1 00000000 d

/* project.f */
+incdir+.
dram_port_pkg.sv
dram_spill_reg.sv
dram_id_ctrl.sv
dram_port_top.sv
tb_dram_port_asserts.sv
tb_dram_port.sv

/* run.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_dram_port \
  -f project.f \
  -o sim_tb_dram_port

./obj_dir/sim_tb_dram_port | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "run.sh: testbench passed"
  exit 0
else
  echo "run.sh: testbench did not pass"
  exit 1
fi
